/* rtl/zx_mem_pkg.sv */
/*
 Shared types and constants for the Spectrum memory paging core.
 RAM addresses are byte addresses into a 16-bit wide SDRAM.
 The memory mode encoding follows the configuration menu order.
 Bank numbers are 16K units counted from address zero of the RAM.
*/
`default_nettype none

package zx_mem_pkg;

	// ========================================================================
	// Widths with a meaning
	// ========================================================================
	typedef logic [15:0] cpu_addr_t;   // Z80 address
	typedef logic [7:0]  byte_t;
	typedef logic [23:0] ram_addr_t;   // Byte address in SDRAM
	typedef logic [15:0] ram_word_t;   // One SDRAM word

	// Memory model, sampled at reset
	typedef enum logic [2:0] {
		MODE_STD128    = 3'd0,
		MODE_P1024     = 3'd1,
		MODE_PROFI1024 = 3'd2,
		MODE_ZX48      = 3'd3,
		MODE_PLUS3     = 3'd4
	} mem_mode_e;

	// ========================================================================
	// Bundles
	// ========================================================================
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     dout;     // CPU write data
		logic      io_wr;
		logic      mem_rd;
		logic      mem_wr;
	} cpu_bus_t;

	typedef struct packed {
		byte_t     reg_7ffd;
		byte_t     reg_1ffd;
		byte_t     reg_eff7;
		logic [2:0] page_ext;  // Upper RAM bank bits (1024K machines)
		mem_mode_e mode;
	} page_state_t;

	// Request toward the SDRAM controller
	typedef struct packed {
		ram_addr_t addr;
		ram_word_t din;      // Write byte in both halves
		logic [1:0] ds;      // Byte lanes, high then low
		logic      we;
	} ram_req_t;

	typedef enum logic {
		PORT_IDLE,
		PORT_WAIT
	} port_state_e;

	// Fixed banks of the 4000 and 8000 windows
	localparam logic [2:0] BANK_SCREEN = 3'd5;
	localparam logic [2:0] BANK_MID    = 3'd2;

endpackage

`default_nettype wire

/* rtl/paging_regs.sv */
/*
 Paging registers for 128K, +3, Profi and Pentagon 1024 machines.
 Writes take effect on the rising edge of io_wr, so io_wr must be
 low for at least one clock between two port writes.
 The memory mode is taken from mode_cfg only while reset is high.
 The lock bit holds all ports until the next reset.
*/
`default_nettype none

module paging_regs import zx_mem_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_bus_t    cpu,
	input  mem_mode_e   mode_cfg,
	output page_state_t page_state
);

	logic      io_wr_d;
	logic      io_wr_rise;
	logic      zx48;
	logic      plus3;
	logic      p1024;
	logic      pf1024;
	logic      page_disable;
	logic      sel_7ffd;
	logic      sel_1ffd;
	logic      sel_dffd;
	logic      sel_eff7;
	cpu_addr_t a;

	assign a = cpu.addr;

	// Mode flags
	assign zx48   = (page_state.mode == MODE_ZX48);
	assign plus3  = (page_state.mode == MODE_PLUS3);
	assign p1024  = (page_state.mode == MODE_P1024);
	assign pf1024 = (page_state.mode == MODE_PROFI1024);

	// ========================================================================
	// Paging lock
	// ========================================================================
	// Pentagon 1024 only honours 7FFD bit 5 when EFF7 bit 2 allows it
	assign page_disable = zx48
		| (~p1024 & page_state.reg_7ffd[5])
		| (p1024 & page_state.reg_eff7[2] & page_state.reg_7ffd[5]);

	// ========================================================================
	// Port decode
	// ========================================================================
	// +3 needs A14 to tell 7FFD apart from 1FFD
	assign sel_7ffd = ~a[15] & ~a[1] & (a[14] | ~plus3);
	assign sel_1ffd = plus3 & (a[15:12] == 4'b0001) & ~a[1];
	assign sel_dffd = pf1024 & (a == 16'hDFFD);   // Full decode on Profi
	assign sel_eff7 = p1024 & (a[15:13] == 3'b111) & ~a[12] & ~a[3];

	assign io_wr_rise = cpu.io_wr & ~io_wr_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d             <= 1'b0;
			page_state.reg_7ffd <= '0;
			page_state.reg_1ffd <= '0;
			page_state.reg_eff7 <= '0;
			page_state.page_ext <= '0;
			page_state.mode     <= mode_cfg;   // Model fixed until next reset
		end else begin
			io_wr_d <= cpu.io_wr;

			if (io_wr_rise && !page_disable) begin
				if (sel_7ffd) begin
					page_state.reg_7ffd <= cpu.dout;
					// Pentagon extra bank bits ride on D7..D5
					if (p1024 && !page_state.reg_eff7[2])
						page_state.page_ext <= {cpu.dout[5], cpu.dout[7:6]};
				end else if (sel_1ffd) begin
					page_state.reg_1ffd <= cpu.dout;
				end

				if (sel_dffd)
					page_state.page_ext <= cpu.dout[2:0];   // Profi bank extension

				if (sel_eff7)
					page_state.reg_eff7 <= cpu.dout;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/page_mapper.sv */
/*
 Translates a CPU address into an SDRAM byte address.
 Purely combinational, valid as soon as page_state and addr settle.
 ROM pages sit above ROM_BASE in 16K steps, which must be a multiple
 of 40000 hex. RAM banks start at address zero.
 ROM is read only except in the +3 all-RAM modes.
*/
`default_nettype none

module page_mapper import zx_mem_pkg::*; #(
	parameter ram_addr_t ROM_BASE = 24'h200000
) (
	input  page_state_t page_state,
	input  cpu_addr_t   addr,
	output ram_addr_t   map_addr,
	output logic        map_wr_ok
);

	logic       plus3;
	logic       zx48;
	logic       special;
	logic       rom_area;
	logic [3:0] rom_page;
	logic [5:0] bank;       // 16K RAM bank number
	logic [2:0] sp_bank;
	ram_addr_t  rom_addr;

	// Bank layout of the +3 all-RAM configurations
	function automatic logic [2:0] special_bank(
		input logic [1:0] cfg,
		input logic [1:0] region
	);
		case (cfg)
			2'b00: special_bank = {1'b0, region};              // 0,1,2,3
			2'b01: special_bank = {1'b1, region};              // 4,5,6,7
			2'b10: begin
				if (region == 2'd3)
					special_bank = 3'd3;                        // 4,5,6,3
				else
					special_bank = {1'b1, region};
			end
			default: begin
				if (region == 2'd3)
					special_bank = 3'd3;                        // 4,7,6,3
				else if (region == 2'd1)
					special_bank = 3'd7;
				else
					special_bank = {1'b1, region};
			end
		endcase
	endfunction

	assign plus3    = (page_state.mode == MODE_PLUS3);
	assign zx48     = (page_state.mode == MODE_ZX48);
	assign special  = page_state.reg_1ffd[0];
	assign rom_area = (addr[15:14] == 2'b00);

	// ========================================================================
	// ROM page select
	// ========================================================================
	always_comb begin
		if (plus3)
			rom_page = {2'b01, page_state.reg_1ffd[2], page_state.reg_7ffd[4]};
		else
			rom_page = {zx48, 2'b01, zx48 | page_state.reg_7ffd[4]};
	end

	assign rom_addr = ROM_BASE + {6'd0, rom_page, 14'd0};

	// ========================================================================
	// RAM bank select
	// ========================================================================
	always_comb begin
		sp_bank = special_bank(page_state.reg_1ffd[2:1], addr[15:14]);
		case (addr[15:14])
			2'b01:   bank = {3'd0, BANK_SCREEN};
			2'b10:   bank = {3'd0, BANK_MID};
			default: bank = {page_state.page_ext, page_state.reg_7ffd[2:0]};
		endcase

		if (special)
			map_addr = {7'd0, sp_bank, addr[13:0]};
		else if (rom_area)
			map_addr = rom_addr | {10'd0, addr[13:0]};
		else
			map_addr = {4'd0, bank, addr[13:0]};
	end

	assign map_wr_ok = ~(rom_area & ~special);   // ROM write protect

endmodule

`default_nettype wire

/* rtl/sdram_port.sv */
/*
 CPU side request port toward a 16-bit SDRAM controller.
 Each access flips ram_req_tgl once; the controller flips ram_ack_tgl
 when done. Both toggles live in the clk_sys domain.
 The CPU may only start a new access while ram_ready is high.
 ram_q must hold read data until the next request is issued.
*/
`default_nettype none

module sdram_port import zx_mem_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  cpu,
	input  ram_addr_t map_addr,
	input  logic      map_wr_ok,
	output ram_req_t  ram_req_out,
	output logic      ram_req_tgl,
	input  logic      ram_ack_tgl,
	input  ram_word_t ram_q,
	output byte_t     ram_dout,
	output logic      ram_ready
);

	port_state_e state;
	logic        rd_d;
	logic        wr_d;
	logic        rd_start;
	logic        wr_start;
	logic        new_req;
	logic        ack_match;
	logic        req_we;
	ram_addr_t   req_addr;
	ram_word_t   req_din;
	logic [1:0]  req_ds;

	// Strobe edges, ROM writes are dropped here
	assign rd_start  = cpu.mem_rd & ~rd_d;
	assign wr_start  = cpu.mem_wr & ~wr_d & map_wr_ok;
	assign new_req   = rd_start | wr_start;
	assign ack_match = (ram_ack_tgl == ram_req_tgl);

	// ========================================================================
	// Request control
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_d        <= 1'b0;
			wr_d        <= 1'b0;
			ram_req_tgl <= 1'b0;
			req_we      <= 1'b0;
			state       <= PORT_IDLE;
		end else begin
			rd_d <= cpu.mem_rd;
			wr_d <= cpu.mem_wr;

			if (new_req) begin
				ram_req_tgl <= ~ram_req_tgl;   // Hand a new access over
				req_we      <= wr_start;
				state       <= PORT_WAIT;
			end else if (state == PORT_WAIT && ack_match) begin
				state <= PORT_IDLE;
			end
		end
	end

	// Request payload
	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			req_addr <= map_addr;
			req_din  <= {cpu.dout, cpu.dout};
			// Odd byte in the upper lane
			req_ds   <= wr_start ? {map_addr[0], ~map_addr[0]} : 2'b11;
		end
	end

	assign ram_req_out.addr = req_addr;
	assign ram_req_out.din  = req_din;
	assign ram_req_out.ds   = req_ds;
	assign ram_req_out.we   = req_we;

	// ========================================================================
	// Return path
	// ========================================================================
	assign ram_dout  = req_addr[0] ? ram_q[15:8] : ram_q[7:0];
	assign ram_ready = ~new_req & ((state == PORT_IDLE) | ack_match);

endmodule

`default_nettype wire

/* rtl/zx_memory_top.sv */
/*
 Memory paging core of a Spectrum family machine.
 Port writes change paging one clock after the io_wr edge.
 Memory accesses are passed on to the SDRAM with a toggle handshake
 and ram_ready is the CPU wait line.
 ROM_BASE places the ROM images in SDRAM.
*/
`default_nettype none

module zx_memory_top import zx_mem_pkg::*; #(
	parameter ram_addr_t ROM_BASE = 24'h200000
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  cpu,
	input  mem_mode_e mode_cfg,
	output ram_req_t  ram_req_out,
	output logic      ram_req_tgl,
	input  logic      ram_ack_tgl,
	input  ram_word_t ram_q,
	output byte_t     ram_dout,
	output logic      ram_ready
);

	page_state_t page_state;
	ram_addr_t   map_addr;
	logic        map_wr_ok;

	paging_regs paging_regs_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu        (cpu),
		.mode_cfg   (mode_cfg),
		.page_state (page_state)
	);

	page_mapper #(
		.ROM_BASE (ROM_BASE)
	) page_mapper_i (
		.page_state (page_state),
		.addr       (cpu.addr),
		.map_addr   (map_addr),
		.map_wr_ok  (map_wr_ok)
	);

	sdram_port sdram_port_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu         (cpu),
		.map_addr    (map_addr),
		.map_wr_ok   (map_wr_ok),
		.ram_req_out (ram_req_out),
		.ram_req_tgl (ram_req_tgl),
		.ram_ack_tgl (ram_ack_tgl),
		.ram_q       (ram_q),
		.ram_dout    (ram_dout),
		.ram_ready   (ram_ready)
	);

endmodule

`default_nettype wire

/* testbench/zx_memory_sva.sv */
/*
 Handshake assertions for the SDRAM request port, bound into every
 sdram_port instance. They hold only when the CPU side honours
 ram_ready before it raises a new strobe, and when the controller
 clears its acknowledge toggle in reset.
*/
`default_nettype none

module zx_memory_sva import zx_mem_pkg::*; (
	input logic     clk_sys,
	input logic     reset,
	input cpu_bus_t cpu,
	input ram_req_t ram_req_out,
	input logic     ram_req_tgl,
	input logic     ram_ack_tgl,
	input logic     ram_ready
);

	// Payload must not move while the controller works on it
	req_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(ram_req_tgl != ram_ack_tgl) |=> $stable(ram_req_out))
		else $error("request changed while pending");

	// CPU back-pressure
	strobe_when_ready: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(cpu.mem_rd) || $rose(cpu.mem_wr)) |-> $past(ram_ready))
		else $error("strobe raised while ram_ready was low");

	// No access pending and the CPU not held while in reset
	tgl_quiet_in_reset: assert property (@(posedge clk_sys)
		reset |=> (ram_req_tgl == 1'b0) && ram_ready)
		else $error("request toggle or ready wrong during reset");

endmodule

bind sdram_port zx_memory_sva sva_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.cpu         (cpu),
	.ram_req_out (ram_req_out),
	.ram_req_tgl (ram_req_tgl),
	.ram_ack_tgl (ram_ack_tgl),
	.ram_ready   (ram_ready)
);

`default_nettype wire

/* testbench/tb_zx_memory.sv */
/*
 Directed testbench for the memory paging core.
 The SDRAM model acknowledges after 1 to 6 clocks and returns an
 address dependent pattern for words that were never written.
 Outputs are sampled on the falling clock edge.
*/
`default_nettype none

module tb_zx_memory import zx_mem_pkg::*;;

	localparam ram_addr_t ROM_BASE    = 24'h200000;
	localparam int        CYCLE_LIMIT = 4000;   // Several times the test length

	logic      clk_sys = 1'b0;
	logic      reset = 1'b1;
	cpu_bus_t  cpu = '0;
	mem_mode_e mode_cfg = MODE_STD128;
	ram_req_t  ram_req_out;
	logic      ram_req_tgl;
	logic      ram_ack_tgl = 1'b0;
	ram_word_t ram_q = '0;
	byte_t     ram_dout;
	logic      ram_ready;

	int        errors = 0;
	int        checks = 0;
	int        cycles = 0;
	logic      ready_in_access = 1'b0;   // ram_ready one clock into the last access

	// Responder state
	ram_word_t   mem [int unsigned];
	logic        busy = 1'b0;
	int          delay = 0;
	logic [31:0] lcg_state = 32'd62;

	zx_memory_top #(
		.ROM_BASE (ROM_BASE)
	) dut_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu         (cpu),
		.mode_cfg    (mode_cfg),
		.ram_req_out (ram_req_out),
		.ram_req_tgl (ram_req_tgl),
		.ram_ack_tgl (ram_ack_tgl),
		.ram_q       (ram_q),
		.ram_dout    (ram_dout),
		.ram_ready   (ram_ready)
	);

	initial begin
		forever #20 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// SDRAM responder model
	// ========================================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return (x * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
	endfunction

	function automatic ram_word_t mem_read(input int unsigned w);
		if (mem.exists(w))
			return mem[w];
		return w[15:0] ^ {w[22:16], 9'h0ab};   // Untouched words
	endfunction

	function automatic ram_word_t merge_lanes(input ram_word_t old, input ram_word_t din,
		input logic [1:0] ds);
		ram_word_t r;
		r = old;
		if (ds[1])
			r[15:8] = din[15:8];
		if (ds[0])
			r[7:0] = din[7:0];
		return r;
	endfunction

	always @(posedge clk_sys) begin
		if (reset) begin
			ram_ack_tgl <= 1'b0;
			busy        <= 1'b0;
		end else if (!busy) begin
			if (ram_req_tgl != ram_ack_tgl) begin
				lcg_state <= lcg_next(lcg_state);
				delay     <= 1 + int'((lcg_next(lcg_state) >> 16) % 6);
				busy      <= 1'b1;
			end
		end else if (delay > 1) begin
			delay <= delay - 1;
		end else begin
			if (ram_req_out.we)
				mem[ram_req_out.addr[23:1]] = merge_lanes(mem_read(ram_req_out.addr[23:1]),
					ram_req_out.din, ram_req_out.ds);
			else
				ram_q <= mem_read(ram_req_out.addr[23:1]);
			ram_ack_tgl <= ~ram_ack_tgl;   // Access done
			busy        <= 1'b0;
		end
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d clock cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================
	task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic apply_reset(input mem_mode_e mode);
		@(posedge clk_sys);
		reset    <= 1'b1;
		mode_cfg <= mode;
		cpu      <= '0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic io_write(input cpu_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		cpu.addr  <= addr;
		cpu.dout  <= data;
		cpu.io_wr <= 1'b1;
		@(posedge clk_sys);
		cpu.io_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	// One memory access; returns the captured request and the read byte
	task automatic mem_access(input cpu_addr_t addr, input logic wr, input byte_t data,
		output ram_req_t req, output logic toggled, output byte_t rdata);
		logic tgl_before;
		@(negedge clk_sys);
		while (!ram_ready)
			@(negedge clk_sys);
		tgl_before = ram_req_tgl;
		@(posedge clk_sys);
		cpu.addr   <= addr;
		cpu.dout   <= data;
		cpu.mem_rd <= ~wr;
		cpu.mem_wr <= wr;
		@(posedge clk_sys);
		@(negedge clk_sys);
		toggled         = (ram_req_tgl != tgl_before);
		req             = ram_req_out;
		ready_in_access = ram_ready;
		@(posedge clk_sys);
		cpu.mem_rd <= 1'b0;
		cpu.mem_wr <= 1'b0;
		@(negedge clk_sys);
		while (!ram_ready)
			@(negedge clk_sys);
		rdata = ram_dout;
	endtask

	task automatic read_check(input string msg, input cpu_addr_t addr, input ram_addr_t exp);
		ram_req_t req;
		logic     tg;
		byte_t    d;
		mem_access(addr, 1'b0, 8'h00, req, tg, d);
		check({msg, " toggle"}, tg, 1'b1);
		check({msg, " addr"}, req.addr, exp);
		check({msg, " we"}, req.we, 1'b0);
	endtask

	function automatic ram_addr_t rom_at(input int page, input cpu_addr_t a);
		return ROM_BASE + ram_addr_t'(page) * 24'h4000 + ram_addr_t'(a[13:0]);
	endfunction

	function automatic ram_addr_t bank_at(input int bank, input cpu_addr_t a);
		return ram_addr_t'(bank) * 24'h4000 + ram_addr_t'(a[13:0]);
	endfunction

	// ========================================================================
	// Directed tests
	// ========================================================================
	task automatic test_reset_state();
		apply_reset(MODE_STD128);
		@(negedge clk_sys);
		check("ready after reset", ram_ready, 1'b1);
		check("toggle after reset", ram_req_tgl, 1'b0);
		read_check("reset C000", 16'hC000, bank_at(0, 16'hC000));
		read_check("reset ROM", 16'h0000, rom_at(2, 16'h0000));
	endtask

	task automatic test_7ffd_lock();
		apply_reset(MODE_STD128);
		io_write(16'h7FFD, 8'h03);
		read_check("7ffd bank3", 16'hC010, bank_at(3, 16'hC010));
		read_check("7ffd rom0", 16'h0123, rom_at(2, 16'h0123));
		io_write(16'h7FFD, 8'h10);
		read_check("7ffd rom1", 16'h0123, rom_at(3, 16'h0123));
		io_write(16'h7FFD, 8'h21);   // Bank 1 and lock
		io_write(16'h7FFD, 8'h04);
		read_check("locked bank", 16'hC000, bank_at(1, 16'hC000));
		apply_reset(MODE_ZX48);
		io_write(16'h7FFD, 8'h03);
		read_check("48k bank", 16'hC000, bank_at(0, 16'hC000));
		read_check("48k rom", 16'h0000, rom_at(11, 16'h0000));
	endtask

	task automatic test_plus3();
		ram_req_t req;
		logic     tg;
		byte_t    d;
		apply_reset(MODE_PLUS3);
		for (int i = 0; i < 4; i++) begin
			io_write(16'h1FFD, byte_t'((i >> 1) << 2));
			io_write(16'h7FFD, byte_t'((i & 1) << 4));
			read_check("+3 rom", 16'h0040, rom_at(4 + i, 16'h0040));
		end
		io_write(16'h1FFD, 8'h07);   // All-RAM 4,7,6,3
		read_check("special 0000", 16'h0000, bank_at(4, 16'h0000));
		read_check("special 4000", 16'h4000, bank_at(7, 16'h4000));
		read_check("special 8000", 16'h8000, bank_at(6, 16'h8000));
		read_check("special C000", 16'hC000, bank_at(3, 16'hC000));
		mem_access(16'h0002, 1'b1, 8'h5A, req, tg, d);
		check("special write toggle", tg, 1'b1);
		check("special write addr", req.addr, bank_at(4, 16'h0002));
		mem_access(16'h0002, 1'b0, 8'h00, req, tg, d);
		check("special read back", d, 8'h5A);
	endtask

	task automatic test_ext_banks();
		apply_reset(MODE_P1024);
		io_write(16'h7FFD, 8'hA2);   // Ext {1,1,0}
		read_check("p1024 A2", 16'hC000, bank_at(6 * 8 + 2, 16'hC000));
		io_write(16'h7FFD, 8'h42);   // Ext {0,0,1}
		read_check("p1024 42", 16'hC100, bank_at(1 * 8 + 2, 16'hC100));
		apply_reset(MODE_PROFI1024);
		io_write(16'hDFFD, 8'h05);
		io_write(16'h7FFD, 8'h03);
		read_check("profi", 16'hC000, bank_at(5 * 8 + 3, 16'hC000));
	endtask

	task automatic test_writes();
		ram_req_t req;
		logic     tg;
		byte_t    d;
		apply_reset(MODE_STD128);
		mem_access(16'h0005, 1'b1, 8'h55, req, tg, d);
		check("rom write toggle", tg, 1'b0);
		check("rom write ready", ready_in_access, 1'b1);
		mem_access(16'hC001, 1'b1, 8'hA5, req, tg, d);
		check("odd write busy", ready_in_access, 1'b0);
		check("odd write ds", req.ds, 2'b10);
		check("odd write we", req.we, 1'b1);
		check("odd write din", req.din, 16'hA5A5);
		check("odd write addr", req.addr, bank_at(0, 16'hC001));
		mem_access(16'hC000, 1'b1, 8'h3C, req, tg, d);
		check("even write ds", req.ds, 2'b01);
		mem_access(16'hC001, 1'b0, 8'h00, req, tg, d);
		check("odd read back", d, 8'hA5);
		mem_access(16'hC000, 1'b0, 8'h00, req, tg, d);
		check("even read back", d, 8'h3C);
		for (int i = 0; i < 6; i++) begin
			mem_access(16'h8000 + cpu_addr_t'(i * 37), 1'b1, byte_t'(8'h11 * i + 1), req, tg, d);
			mem_access(16'h8000 + cpu_addr_t'(i * 37), 1'b0, 8'h00, req, tg, d);
			check("bank2 read back", d, byte_t'(8'h11 * i + 1));
		end
	endtask

	initial begin
		test_reset_state();
		test_7ffd_lock();
		test_plus3();
		test_ext_banks();
		test_writes();
		repeat (4) @(posedge clk_sys);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/zx_mem_pkg.sv
rtl/paging_regs.sv
rtl/page_mapper.sv
rtl/sdram_port.sv
rtl/zx_memory_top.sv
testbench/zx_memory_sva.sv
testbench/tb_zx_memory.sv

/* Makefile */
# Verilator simulation of the memory paging core

VERILATOR ?= verilator
TOP       ?= tb_zx_memory
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation did not finish, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
